//--- sources.f
+incdir+verification
src/aes_pkg.sv
src/aes_spi_port.sv
src/aes_control.sv
src/aes_key_expand.sv
src/aes_state_feed.sv
src/aes_column_lane.sv
src/aes_round_collect.sv
src/aes_top.sv
verification/aes_tb.sv

//--- Bender.yml
package:
  name: aes_spi_engine

sources:
  - files:
      - src/aes_pkg.sv
      - src/aes_spi_port.sv
      - src/aes_control.sv
      - src/aes_key_expand.sv
      - src/aes_state_feed.sv
      - src/aes_column_lane.sv
      - src/aes_round_collect.sv
      - src/aes_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/aes_tb.sv

//--- verification/aes_tb_vectors.svh
/*
 * Known-answer table for the AES-128 testbench, included inside aes_tb.
 * One row per encryption, applied in order by the test loop.
 */

`ifndef AES_TB_VECTORS_SVH
`define AES_TB_VECTORS_SVH

// one encryption request and its answer
typedef struct packed {
	logic [127:0] key;
	logic [127:0] plaintext;
	logic [127:0] expected;
} vector_t;

localparam int NUM_VECTORS = 3;

// columns in struct order: key, plaintext, expected ciphertext
localparam vector_t VECTORS [NUM_VECTORS] = '{
	// FIPS-197 appendix C.1
	{
		128'h000102030405060708090a0b0c0d0e0f,
		128'h00112233445566778899aabbccddeeff,
		128'h69c4e0d86a7b0430d8cdb78070b4c55a
	},
	// FIPS-197 appendix B
	{
		128'h2b7e151628aed2a6abf7158809cf4f3c,
		128'h3243f6a8885a308d313198a2e0370734,
		128'h3925841d02dc09fbdc118597196a0b32
	},
	// all zero key and block
	{
		128'h00000000000000000000000000000000,
		128'h00000000000000000000000000000000,
		128'h66e94bd4ef8a2c3b884cfa59ca342b2e
	}
};

`endif

//--- verification/aes_tb.sv
/*
 * Testbench for the AES-128 SPI engine. Each table row is shifted in over
 * sck, the run is timed against done, and the ciphertext is shifted back out.
 */

`timescale 1ns/1ps

module aes_tb;

	localparam int SYNC_STAGES = 2;
	// sck level hold in clk cycles, must exceed SYNC_STAGES + 3
	localparam int SCK_HALF = 6;
	// edges from the one that samples load low to the one that sets done
	localparam int DONE_EDGES = 12;
	localparam int DONE_TIMEOUT = 40;
	localparam int CLEAR_TIMEOUT = 3;

	`include "aes_tb_vectors.svh"

	logic clk;
	logic reset;
	logic sck;
	logic sdi;
	logic load;
	logic sdo;
	logic done;

	logic [127:0] captured;
	int edges;

	aes_top #(
		.SYNC_STAGES(SYNC_STAGES)
	) dut (
		.clk(clk),
		.reset(reset),
		.sck(sck),
		.sdi(sdi),
		.load(load),
		.sdo(sdo),
		.done(done)
	);

	// 8 ns period
	always #4 clk = ~clk;

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic check_value(input string test_name, input logic [127:0] expected,
			input logic [127:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %0h, actual %0h", test_name, expected, actual);
			$display("Errors found");
			$fatal(1, "value mismatch in %s", test_name);
		end
	endtask

	// condition never arrived, say which one and stop
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Errors found");
		$fatal(1, "run stopped on timeout");
	endtask

	// every input change happens right after a falling edge
	task automatic hold_clocks(input int n);
		repeat (n) @(negedge clk);
	endtask

	// after load rises, done must drop
	task automatic wait_done_clear();
		int clocks;
		clocks = 0;
		while (done && clocks < CLEAR_TIMEOUT) begin
			@(negedge clk);
			clocks++;
		end
		if (done) begin
			abort_run("done did not clear within 3 clocks of load rising");
		end
	endtask

	task automatic wait_for_done(output int edges_seen);
		int clocks;
		clocks = 0;
		while (!done && clocks < DONE_TIMEOUT) begin
			@(negedge clk);
			clocks++;
		end
		if (!done) begin
			abort_run("done never rose within 40 clocks of load falling");
		end
		// first counted edge is the one that samples load low
		edges_seen = clocks - 1;
	endtask

	//////////////////////////////
	// SPI master, mode 0
	//////////////////////////////

	// plaintext then key, msb first
	task automatic spi_load(input logic [255:0] bits);
		for (int i = 255; i >= 0; i--) begin
			sdi = bits[i];
			hold_clocks(SCK_HALF);
			check_value("done low while shifting in", 128'd0, {127'd0, done});
			sck = 1'b1;
			hold_clocks(SCK_HALF);
			sck = 1'b0;
		end
		// last rise clears the synchronizer before load drops
		hold_clocks(SCK_HALF);
	endtask

	task automatic spi_read(output logic [127:0] data);
		data = '0;
		for (int i = 127; i >= 0; i--) begin
			hold_clocks(SCK_HALF);
			// sampled just ahead of the rising sck
			data[i] = sdo;
			sck = 1'b1;
			hold_clocks(SCK_HALF);
			sck = 1'b0;
		end
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		sck = 1'b0;
		sdi = 1'b0;
		load = 1'b0;
		hold_clocks(4);
		reset = 1'b0;
		hold_clocks(1);
		check_value("done after reset", 128'd0, {127'd0, done});
		check_value("sdo after reset", 128'd0, {127'd0, sdo});

		// rows back to back, each with a fresh key
		for (int row = 0; row < NUM_VECTORS; row++) begin
			load = 1'b1;
			wait_done_clear();
			spi_load({VECTORS[row].plaintext, VECTORS[row].key});
			load = 1'b0;
			wait_for_done(edges);
			check_value($sformatf("row %0d done latency", row), DONE_EDGES, edges);
			// msb is on sdo before any sck edge
			check_value($sformatf("row %0d first sdo bit", row),
				{127'd0, VECTORS[row].expected[127]}, {127'd0, sdo});
			spi_read(captured);
			check_value($sformatf("row %0d ciphertext", row), VECTORS[row].expected,
				captured);
		end

		$display("No errors");
		$finish;
	end

endmodule

//--- src/aes_top.sv
/*
 * AES-128 encryption engine behind an SPI port.
 * Host shifts plaintext and key in under load, waits for done,
 * then shifts the ciphertext out.
 */

`timescale 1ns/1ps

module aes_top #(
	parameter int SYNC_STAGES = 2
) (
	input logic clk,
	input logic reset,
	input logic sck,
	input logic sdi,
	input logic load,
	output logic sdo,
	output logic done
);
	import aes_pkg::*;

	block_t key;
	block_t plaintext;
	block_t ciphertext;
	block_t round_key;
	block_t next_state;
	round_ctrl_t round_ctrl;
	word_t lane_in [NUM_COLUMNS];
	word_t lane_out [NUM_COLUMNS];

	//////////////////////////////
	// port and sequencing
	//////////////////////////////

	aes_spi_port #(
		.SYNC_STAGES(SYNC_STAGES)
	) u_spi (
		.clk(clk),
		.reset(reset),
		.sck(sck),
		.sdi(sdi),
		.load(load),
		.done(done),
		.ciphertext(ciphertext),
		.sdo(sdo),
		.key(key),
		.plaintext(plaintext)
	);

	aes_control u_control (
		.clk(clk),
		.reset(reset),
		.load(load),
		.round_ctrl(round_ctrl),
		.done(done)
	);

	aes_key_expand u_key (
		.clk(clk),
		.reset(reset),
		.round_ctrl(round_ctrl),
		.key(key),
		.round_key(round_key)
	);

	//////////////////////////////
	// round loop
	//////////////////////////////

	aes_state_feed u_feed (
		.clk(clk),
		.reset(reset),
		.next_state(next_state),
		.lane_in(lane_in)
	);

	// one lane per column
	for (genvar k = 0; k < NUM_COLUMNS; k++) begin : g_lane
		aes_column_lane u_lane (
			.column(lane_in[k]),
			.final_round(round_ctrl.final_round),
			.mixed(lane_out[k])
		);
	end

	aes_round_collect u_collect (
		.clk(clk),
		.reset(reset),
		.round_ctrl(round_ctrl),
		.plaintext(plaintext),
		.round_key(round_key),
		.key(key),
		.lane_out(lane_out),
		.next_state(next_state),
		.ciphertext(ciphertext)
	);

endmodule

//--- src/aes_round_collect.sv
/*
 * Joins the lane columns and adds the round key to form the next state.
 * Seeds the state with plaintext xor key at start and keeps the
 * ciphertext from the final round.
 */

`timescale 1ns/1ps

module aes_round_collect (
	input logic clk,
	input logic reset,
	input aes_pkg::round_ctrl_t round_ctrl,
	input aes_pkg::block_t plaintext,
	input aes_pkg::block_t round_key,
	input aes_pkg::block_t key,
	input aes_pkg::word_t lane_out [aes_pkg::NUM_COLUMNS],
	output aes_pkg::block_t next_state,
	output aes_pkg::block_t ciphertext
);
	import aes_pkg::*;

	block_t joined;
	block_t round_result;

	always_comb begin
		for (int k = 0; k < NUM_COLUMNS; k++) begin
			joined[k] = lane_out[k];
		end
	end

	// AddRoundKey
	assign round_result = joined ^ round_key;
	// initial key addition at start
	assign next_state = round_ctrl.start ? (plaintext ^ key) : round_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			ciphertext <= '0;
		end else if (round_ctrl.advance && round_ctrl.final_round) begin
			ciphertext <= round_result;
		end
	end

endmodule

//--- src/aes_column_lane.sv
/*
 * One column of a round: SubBytes on four bytes, then MixColumns.
 * MixColumns is bypassed in the final round. Purely combinational.
 */

`timescale 1ns/1ps

module aes_column_lane (
	input aes_pkg::word_t column,
	input logic final_round,
	output aes_pkg::word_t mixed
);
	import aes_pkg::*;

	word_t sub;
	word_t mix;
	// xor of all four substituted bytes
	byte_t sum;

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			sub[i] = SBOX[column[i]];
		end
		sum = sub[0] ^ sub[1] ^ sub[2] ^ sub[3];
		// lightweight form: y_i = a_i ^ sum ^ 2*(a_i ^ a_i+1)
		for (int i = 0; i < 4; i++) begin
			mix[i] = sub[i] ^ sum ^ xtime(sub[i] ^ sub[(i + 1) % 4]);
		end
	end

	// last round skips MixColumns
	assign mixed = final_round ? sub : mix;

endmodule

//--- src/aes_state_feed.sv
/*
 * Cipher state register. It reloads from the round collector every clock
 * and hands each lane its column with ShiftRows already applied.
 */

`timescale 1ns/1ps

module aes_state_feed (
	input logic clk,
	input logic reset,
	input aes_pkg::block_t next_state,
	output aes_pkg::word_t lane_in [aes_pkg::NUM_COLUMNS]
);
	import aes_pkg::*;

	// state[c][r] is row r of column c
	block_t state_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= '0;
		end else begin
			state_q <= next_state;
		end
	end

	//////////////////////////////
	// ShiftRows while dealing
	//////////////////////////////

	// row r rotated left by r, so lane c takes row r from column c+r.
	// SubBytes is byte-local, so shifting ahead of it changes nothing
	always_comb begin
		for (int c = 0; c < NUM_COLUMNS; c++) begin
			for (int r = 0; r < 4; r++) begin
				lane_in[c][r] = state_q[(c + r) % NUM_COLUMNS][r];
			end
		end
	end

endmodule

//--- src/aes_key_expand.sv
/*
 * On-the-fly AES-128 key schedule.
 * The register takes the cipher key at start and steps one round key
 * per round; round_key is the key of the round being computed.
 */

`timescale 1ns/1ps

module aes_key_expand (
	input logic clk,
	input logic reset,
	input aes_pkg::round_ctrl_t round_ctrl,
	input aes_pkg::block_t key,
	output aes_pkg::block_t round_key
);
	import aes_pkg::*;

	// key of the previous round
	block_t key_q;
	word_t rot_w3;
	word_t sub_w3;

	//////////////////////////////
	// next round key
	//////////////////////////////

	always_comb begin
		// RotWord on the last column
		rot_w3 = {key_q[3][1], key_q[3][2], key_q[3][3], key_q[3][0]};
		sub_w3 = sub_word(rot_w3);
		round_key[0] = key_q[0] ^ sub_w3 ^ rcon_of(round_ctrl.round);
		// each later word chains off the new word before it
		for (int k = 1; k < NUM_COLUMNS; k++) begin
			round_key[k] = key_q[k] ^ round_key[k-1];
		end
	end

	//////////////////////////////
	// key register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			key_q <= '0;
		end else if (round_ctrl.start) begin
			key_q <= key;
		end else if (round_ctrl.advance) begin
			key_q <= round_key;
		end
	end

endmodule

//--- src/aes_control.sv
/*
 * Round sequencer. A falling load starts a run of ten rounds,
 * one per clock, and done follows until load rises again.
 */

`timescale 1ns/1ps

module aes_control (
	input logic clk,
	input logic reset,
	input logic load,
	output aes_pkg::round_ctrl_t round_ctrl,
	output logic done
);
	import aes_pkg::*;

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	round_t round_q;
	logic load_q;
	logic start_q;

	// start pulse: previous sample high, current sample low
	always_ff @(posedge clk) begin
		if (reset) begin
			load_q <= 1'b0;
			start_q <= 1'b0;
			state_q <= ctrl_idle;
			round_q <= '0;
			done <= 1'b0;
		end else begin
			load_q <= load;
			start_q <= load_q & ~load;
			state_q <= state_d;
			// round 1 on entry, then count up
			if (state_d == ctrl_run) begin
				round_q <= (state_q == ctrl_run) ? round_q + 4'd1 : 4'd1;
			end else if (state_d == ctrl_idle) begin
				round_q <= '0;
			end
			// one cycle behind the done state
			done <= (state_q == ctrl_done) && !load;
		end
	end

	// load high always wins and drops back to idle
	always_comb begin
		state_d = state_q;
		if (load) begin
			state_d = ctrl_idle;
		end else begin
			case (state_q)
				ctrl_idle: if (start_q) state_d = ctrl_run;
				ctrl_run: if (round_q == round_t'(NUM_ROUNDS)) state_d = ctrl_done;
				ctrl_done: state_d = ctrl_done;
				default: state_d = ctrl_idle;
			endcase
		end
	end

	assign round_ctrl.start = start_q;
	assign round_ctrl.advance = (state_q == ctrl_run);
	assign round_ctrl.final_round = (state_q == ctrl_run) && (round_q == round_t'(NUM_ROUNDS));
	assign round_ctrl.round = round_q;

	a_round_bound: assert property (@(posedge clk) disable iff (reset)
		round_ctrl.round <= round_t'(NUM_ROUNDS))
		else $error("round counter ran past the last round");

	a_start_not_in_run: assert property (@(posedge clk) disable iff (reset)
		!(round_ctrl.start && round_ctrl.advance))
		else $error("start arrived during a running encryption");

endmodule

//--- src/aes_spi_port.sv
/*
 * SPI mode 0 slave port, oversampled by clk.
 * Shifts plaintext then key in while load is high and
 * shifts the ciphertext out MSB first once done rises.
 */

`timescale 1ns/1ps

module aes_spi_port #(
	parameter int SYNC_STAGES = 2
) (
	input logic clk,
	input logic reset,
	input logic sck,
	input logic sdi,
	input logic load,
	input logic done,
	input aes_pkg::block_t ciphertext,
	output logic sdo,
	output aes_pkg::block_t key,
	output aes_pkg::block_t plaintext
);
	import aes_pkg::*;

	// synchronizer chains, newest sample in bit 0
	logic [SYNC_STAGES-1:0] sck_sync;
	logic [SYNC_STAGES-1:0] sdi_sync;
	logic sck_prev;
	logic sck_rise;
	logic sck_fall;
	logic sdi_s;
	// {plaintext, key}
	logic [2*BLOCK_BITS-1:0] in_q;
	logic [BLOCK_BITS-1:0] out_q;
	logic [BLOCK_BITS-1:0] cipher_bits;
	logic done_q;
	logic done_rise;

	//////////////////////////////
	// sck and sdi into clk
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			sck_sync <= '0;
			sdi_sync <= '0;
			sck_prev <= 1'b0;
			done_q <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[SYNC_STAGES-2:0], sck};
			sdi_sync <= {sdi_sync[SYNC_STAGES-2:0], sdi};
			sck_prev <= sck_sync[SYNC_STAGES-1];
			done_q <= done;
		end
	end

	// sdi taken from the same stage as the edge, so it lines up
	assign sdi_s = sdi_sync[SYNC_STAGES-1];
	assign sck_rise = sck_sync[SYNC_STAGES-1] & ~sck_prev;
	assign sck_fall = ~sck_sync[SYNC_STAGES-1] & sck_prev;
	assign done_rise = done & ~done_q;

	//////////////////////////////
	// input shifter
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (load && sck_rise) begin
			in_q <= {in_q[2*BLOCK_BITS-2:0], sdi_s};
		end
	end

	assign plaintext = in_q[2*BLOCK_BITS-1:BLOCK_BITS];
	assign key = in_q[BLOCK_BITS-1:0];

	//////////////////////////////
	// output shifter
	//////////////////////////////

	assign cipher_bits = ciphertext;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_q <= '0;
		end else if (done_rise) begin
			out_q <= cipher_bits;
		end else if (done && sck_fall) begin
			// next bit onto sdo after the host sampled
			out_q <= {out_q[BLOCK_BITS-2:0], 1'b0};
		end
	end

	// msb shown in the same cycle done rises, before the shifter is loaded
	assign sdo = done_rise ? cipher_bits[BLOCK_BITS-1] : out_q[BLOCK_BITS-1];

	a_no_shift_before_done: assert property (@(posedge clk) disable iff (reset)
		!done |=> $stable(out_q))
		else $error("output shifter moved while done was low");

endmodule

//--- src/aes_pkg.sv
/*
 * Shared types, constants and GF(2^8) helpers for the AES-128 engine.
 * Every RTL module imports this package. It also holds the S-box table.
 */

package aes_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////

	localparam int NUM_COLUMNS = 4;
	localparam int NUM_ROUNDS = 10;
	localparam int BLOCK_BITS = 128;

	// one state byte
	typedef logic [7:0] byte_t;
	// one column, row 0 in the top byte
	typedef byte_t [0:3] word_t;
	// full block, w0 in bits 127:96
	typedef word_t [0:NUM_COLUMNS-1] block_t;
	// round number 0..10
	typedef logic [3:0] round_t;

	typedef enum logic [1:0] {
		ctrl_idle,
		ctrl_run,
		ctrl_done
	} ctrl_state_e;

	// controller to key path and datapath
	typedef struct packed {
		logic start;
		logic advance;
		logic final_round;
		round_t round;
	} round_ctrl_t;

	//////////////////////////////
	// substitution table
	//////////////////////////////

	localparam byte_t SBOX [0:255] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	// byte-wise substitution of a whole word
	function automatic word_t sub_word(input word_t w);
		word_t result;
		for (int i = 0; i < 4; i++) begin
			result[i] = SBOX[w[i]];
		end
		return result;
	endfunction

	// multiply by x, reduce by x^8+x^4+x^3+x+1
	function automatic byte_t xtime(input byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// round constant sits in the top byte of the word
	function automatic word_t rcon_of(input round_t r);
		byte_t rc;
		case (r)
			4'd1: rc = 8'h01;
			4'd2: rc = 8'h02;
			4'd3: rc = 8'h04;
			4'd4: rc = 8'h08;
			4'd5: rc = 8'h10;
			4'd6: rc = 8'h20;
			4'd7: rc = 8'h40;
			4'd8: rc = 8'h80;
			4'd9: rc = 8'h1b;
			4'd10: rc = 8'h36;
			default: rc = 8'h00;
		endcase
		return {rc, 24'h000000};
	endfunction

endpackage
